//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int WORD_WIDTH = 16;

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [1:0] reg_idx_t;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_NOT    = 3'd4,  // Unary on src_a
        ALU_SHL    = 3'd5,
        ALU_SRA    = 3'd6,
        ALU_PASS_B = 3'd7   // Immediates arrive on src_b
    } alu_op_t;

    // EX/MEM bundle, 56 bits
    typedef struct packed {
        word_t    alu_result;
        word_t    store_data;
        reg_idx_t rd;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        logic     mem_to_reg;
        logic     is_wwd;
        word_t    wwd_data;
        logic     is_halt;
    } ex_mem_t;

    typedef struct packed {
        word_t    wb_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     is_wwd;
        word_t    wwd_data;
        logic     is_halt;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               in_valid,
    input  cpu_pkg::alu_op_t   alu_op,
    input  cpu_pkg::word_t     src_a,
    input  cpu_pkg::word_t     src_b,
    input  cpu_pkg::word_t     store_data,
    input  cpu_pkg::reg_idx_t  rd,
    input  logic               mem_read,
    input  logic               mem_write,
    input  logic               reg_write,
    input  logic               mem_to_reg,
    input  logic               is_wwd,
    input  logic               is_halt,
    output logic               ex_valid,
    output cpu_pkg::ex_mem_t   ex_payload
);

    logic           halt_seen;
    cpu_pkg::word_t alu_result;

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_ADD:    alu_result = src_a + src_b;
            cpu_pkg::ALU_SUB:    alu_result = src_a - src_b;
            cpu_pkg::ALU_AND:    alu_result = src_a & src_b;
            cpu_pkg::ALU_OR:     alu_result = src_a | src_b;
            cpu_pkg::ALU_NOT:    alu_result = ~src_a;
            cpu_pkg::ALU_SHL:    alu_result = src_a << 1;
            cpu_pkg::ALU_SRA:    alu_result = cpu_pkg::word_t'($signed(src_a) >>> 1);
            cpu_pkg::ALU_PASS_B: alu_result = src_b;
            default:             alu_result = '0;
        endcase
    end

    // Nothing issues once a halt has gone down the pipe
    assign ex_valid = in_valid && !halt_seen;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            halt_seen <= 1'b0;
        end else if (ex_valid && is_halt) begin
            halt_seen <= 1'b1;
        end
    end

    always_comb begin
        ex_payload            = '0;
        ex_payload.alu_result = alu_result;
        ex_payload.store_data = store_data;
        ex_payload.rd         = rd;
        ex_payload.mem_read   = mem_read;
        ex_payload.mem_write  = mem_write;
        ex_payload.reg_write  = reg_write;
        ex_payload.mem_to_reg = mem_to_reg;
        ex_payload.is_wwd     = is_wwd;
        ex_payload.wwd_data   = src_a;  // WWD shows the first operand
        ex_payload.is_halt    = is_halt;
    end

    a_no_read_and_write: assert property (
        @(posedge clk) disable iff (reset_n)
        in_valid |-> !(mem_read && mem_write)
    ) else $error("alu_exec: mem_read and mem_write both set on a valid input");

endmodule

`default_nettype wire

//--- stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     out_valid,
    output payload_t out_payload
);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Zero payload clears the control fields too
    always_ff @(posedge clk) begin
        if (reset_n) begin
            out_payload <= '0;
        end else begin
            out_payload <= in_payload;
        end
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (reset_n)
        !$isunknown(out_valid)
    ) else $error("stage_reg: out_valid unknown after reset");

endmodule

`default_nettype wire

//--- mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             in_valid,
    input  cpu_pkg::ex_mem_t in_payload,
    output logic             mem_valid,
    output cpu_pkg::mem_wb_t mem_payload
);

    localparam int ADDR_W = (DMEM_DEPTH > 1) ? $clog2(DMEM_DEPTH) : 1;

    cpu_pkg::word_t dmem [DMEM_DEPTH];
    logic [ADDR_W-1:0] addr;

    cpu_pkg::word_t    rdata_q;
    cpu_pkg::word_t    alu_q;
    cpu_pkg::word_t    wwd_data_q;
    cpu_pkg::reg_idx_t rd_q;
    logic              valid_q;
    logic              reg_write_q;
    logic              mem_to_reg_q;
    logic              is_wwd_q;
    logic              is_halt_q;

    assign addr = in_payload.alu_result[ADDR_W-1:0];

    // Read-before-write, output register on the RAM
    always_ff @(posedge clk) begin
        if (in_valid && in_payload.mem_write) begin
            dmem[addr] <= in_payload.store_data;
        end
        if (in_valid && in_payload.mem_read) begin
            rdata_q <= dmem[addr];
        end
        alu_q      <= in_payload.alu_result;
        wwd_data_q <= in_payload.wwd_data;
        rd_q       <= in_payload.rd;
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            valid_q      <= 1'b0;
            reg_write_q  <= 1'b0;
            mem_to_reg_q <= 1'b0;
            is_wwd_q     <= 1'b0;
            is_halt_q    <= 1'b0;
        end else begin
            valid_q      <= in_valid;
            reg_write_q  <= in_payload.reg_write;
            mem_to_reg_q <= in_payload.mem_to_reg;
            is_wwd_q     <= in_payload.is_wwd;
            is_halt_q    <= in_payload.is_halt;
        end
    end

    assign mem_valid = valid_q;

    always_comb begin
        mem_payload           = '0;
        mem_payload.wb_data   = mem_to_reg_q ? rdata_q : alu_q;  // Load or ALU result
        mem_payload.rd        = rd_q;
        mem_payload.reg_write = reg_write_q;
        mem_payload.is_wwd    = is_wwd_q;
        mem_payload.wwd_data  = wwd_data_q;
        mem_payload.is_halt   = is_halt_q;
    end

    a_addr_in_range: assert property (
        @(posedge clk) disable iff (reset_n)
        (in_valid && (in_payload.mem_read || in_payload.mem_write))
            |-> (int'(in_payload.alu_result) < DMEM_DEPTH)
    ) else $error("mem_access: address %h beyond data memory", in_payload.alu_result);

endmodule

`default_nettype wire

//--- backend_top.sv
`timescale 1ns/1ps
`default_nettype none

module backend_top #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              in_valid,
    input  cpu_pkg::alu_op_t  alu_op,
    input  cpu_pkg::word_t    src_a,
    input  cpu_pkg::word_t    src_b,
    input  cpu_pkg::word_t    store_data,
    input  cpu_pkg::reg_idx_t rd,
    input  logic              mem_read,
    input  logic              mem_write,
    input  logic              reg_write,
    input  logic              mem_to_reg,
    input  logic              is_wwd,
    input  logic              is_halt,
    output logic              wb_valid,
    output cpu_pkg::reg_idx_t wb_rd,
    output cpu_pkg::word_t    wb_data,
    output logic              wb_reg_write,
    output logic              wwd_valid,
    output cpu_pkg::word_t    wwd_data,
    output logic              halted
);

    logic             ex_valid;
    cpu_pkg::ex_mem_t ex_payload;
    logic             exm_valid;
    cpu_pkg::ex_mem_t exm_payload;
    logic             mem_valid;
    cpu_pkg::mem_wb_t mem_payload;
    logic             mwb_valid;
    cpu_pkg::mem_wb_t mwb_payload;
    logic             halt_q;

    alu_exec u_alu_exec (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_valid   (in_valid),
        .alu_op     (alu_op),
        .src_a      (src_a),
        .src_b      (src_b),
        .store_data (store_data),
        .rd         (rd),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .reg_write  (reg_write),
        .mem_to_reg (mem_to_reg),
        .is_wwd     (is_wwd),
        .is_halt    (is_halt),
        .ex_valid   (ex_valid),
        .ex_payload (ex_payload)
    );

    stage_reg #(.payload_t(cpu_pkg::ex_mem_t)) ex_mem_reg (
        .clk         (clk),
        .reset_n     (reset_n),
        .in_valid    (ex_valid),
        .in_payload  (ex_payload),
        .out_valid   (exm_valid),
        .out_payload (exm_payload)
    );

    mem_access #(.DMEM_DEPTH(DMEM_DEPTH)) u_mem_access (
        .clk         (clk),
        .reset_n     (reset_n),
        .in_valid    (exm_valid),
        .in_payload  (exm_payload),
        .mem_valid   (mem_valid),
        .mem_payload (mem_payload)
    );

    stage_reg #(.payload_t(cpu_pkg::mem_wb_t)) mem_wb_reg (
        .clk         (clk),
        .reset_n     (reset_n),
        .in_valid    (mem_valid),
        .in_payload  (mem_payload),
        .out_valid   (mwb_valid),
        .out_payload (mwb_payload)
    );

    // Sticky once the halt reaches writeback
    always_ff @(posedge clk) begin
        if (reset_n) begin
            halt_q <= 1'b0;
        end else if (mwb_valid && mwb_payload.is_halt) begin
            halt_q <= 1'b1;
        end
    end

    assign wb_valid     = mwb_valid;
    assign wb_rd        = mwb_payload.rd;
    assign wb_data      = mwb_payload.wb_data;
    assign wb_reg_write = mwb_valid && mwb_payload.reg_write;
    assign wwd_valid    = mwb_valid && mwb_payload.is_wwd;
    assign wwd_data     = mwb_payload.wwd_data;
    assign halted       = halt_q || (mwb_valid && mwb_payload.is_halt);

endmodule

`default_nettype wire

//--- tb_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_backend;

    localparam int DMEM_DEPTH  = 256;
    localparam int DRAIN_LIMIT = 50;

    logic              clk;
    logic              reset_n;
    logic              in_valid;
    cpu_pkg::alu_op_t  alu_op;
    cpu_pkg::word_t    src_a;
    cpu_pkg::word_t    src_b;
    cpu_pkg::word_t    store_data;
    cpu_pkg::reg_idx_t rd;
    logic              mem_read;
    logic              mem_write;
    logic              reg_write;
    logic              mem_to_reg;
    logic              is_wwd;
    logic              is_halt;
    logic              wb_valid;
    cpu_pkg::reg_idx_t wb_rd;
    cpu_pkg::word_t    wb_data;
    logic              wb_reg_write;
    logic              wwd_valid;
    cpu_pkg::word_t    wwd_data;
    logic              halted;

    int             errors;
    logic [31:0]    rng;
    bit             model_halted;
    cpu_pkg::word_t model_mem [DMEM_DEPTH];
    bit             model_written [DMEM_DEPTH];

    // One entry per accepted instruction
    cpu_pkg::word_t    exp_data_q [$];
    bit                exp_check_q [$];
    cpu_pkg::reg_idx_t exp_rd_q [$];
    bit                exp_rw_q [$];
    bit                exp_wwd_q [$];
    cpu_pkg::word_t    exp_wwd_data_q [$];

    backend_top #(.DMEM_DEPTH(DMEM_DEPTH)) dut0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .in_valid     (in_valid),
        .alu_op       (alu_op),
        .src_a        (src_a),
        .src_b        (src_b),
        .store_data   (store_data),
        .rd           (rd),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .reg_write    (reg_write),
        .mem_to_reg   (mem_to_reg),
        .is_wwd       (is_wwd),
        .is_halt      (is_halt),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .wb_reg_write (wb_reg_write),
        .wwd_valid    (wwd_valid),
        .wwd_data     (wwd_data),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic cpu_pkg::word_t model_alu(input cpu_pkg::alu_op_t op,
                                                 input cpu_pkg::word_t a,
                                                 input cpu_pkg::word_t b);
        cpu_pkg::word_t r;
        case (op)
            cpu_pkg::ALU_ADD: r = a + b;
            cpu_pkg::ALU_SUB: r = a - b;
            cpu_pkg::ALU_AND: r = a & b;
            cpu_pkg::ALU_OR:  r = a | b;
            cpu_pkg::ALU_NOT: r = a ^ 16'hffff;
            cpu_pkg::ALU_SHL: r = {a[14:0], 1'b0};
            cpu_pkg::ALU_SRA: r = {a[15], a[15:1]};  // Sign bit copied in
            default:          r = b;
        endcase
        return r;
    endfunction

    task automatic check_word(input string name, input cpu_pkg::word_t got,
                              input cpu_pkg::word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_rd(input string name, input cpu_pkg::reg_idx_t got,
                            input cpu_pkg::reg_idx_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input bit got, input bit exp);
        if (got != exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_output();
        cpu_pkg::word_t    e_data;
        bit                e_check;
        cpu_pkg::reg_idx_t e_rd;
        bit                e_rw;
        bit                e_wwd;
        cpu_pkg::word_t    e_wwd_data;
        if (exp_data_q.size() == 0) begin
            $display("Output seen at %0t with no instruction left to expect", $time);
            errors++;
        end else begin
            e_data     = exp_data_q.pop_front();
            e_check    = exp_check_q.pop_front();
            e_rd       = exp_rd_q.pop_front();
            e_rw       = exp_rw_q.pop_front();
            e_wwd      = exp_wwd_q.pop_front();
            e_wwd_data = exp_wwd_data_q.pop_front();
            check_flag("wb_valid", wb_valid, 1'b1);
            check_rd("wb_rd", wb_rd, e_rd);
            check_flag("wb_reg_write", wb_reg_write, e_rw);
            check_flag("wwd_valid", wwd_valid, e_wwd);
            if (e_check) begin
                check_word("wb_data", wb_data, e_data);
            end
            if (e_wwd) begin
                check_word("wwd_data", wwd_data, e_wwd_data);
            end
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset_n && (wb_valid || wwd_valid)) begin
            compare_output();
        end
    end

    task automatic send_instr(input cpu_pkg::alu_op_t op, input cpu_pkg::word_t a,
                              input cpu_pkg::word_t b, input cpu_pkg::word_t sd,
                              input cpu_pkg::reg_idx_t r, input bit rw, input bit mr,
                              input bit mw, input bit wwd, input bit hlt);
        cpu_pkg::word_t res;
        cpu_pkg::word_t data;
        bit             chk;
        logic [7:0]     addr;
        res  = model_alu(op, a, b);
        addr = res[7:0];
        @(posedge clk);
        in_valid   <= 1'b1;
        alu_op     <= op;
        src_a      <= a;
        src_b      <= b;
        store_data <= sd;
        rd         <= r;
        reg_write  <= rw;
        mem_read   <= mr;
        mem_write  <= mw;
        mem_to_reg <= mr;
        is_wwd     <= wwd;
        is_halt    <= hlt;
        if (!model_halted) begin
            data = res;
            chk  = 1'b1;
            if (mr) begin
                data = model_mem[addr];
                chk  = model_written[addr];  // Unwritten words are unknown
            end
            if (mw) begin
                model_mem[addr]     = sd;
                model_written[addr] = 1'b1;
            end
            exp_data_q.push_back(data);
            exp_check_q.push_back(chk);
            exp_rd_q.push_back(r);
            exp_rw_q.push_back(rw);
            exp_wwd_q.push_back(wwd);
            exp_wwd_data_q.push_back(a);
            if (hlt) begin
                model_halted = 1'b1;
            end
        end
    endtask

    task automatic idle_input();
        @(posedge clk);
        in_valid  <= 1'b0;
        mem_read  <= 1'b0;
        mem_write <= 1'b0;
        is_halt   <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_n  <= 1'b1;
        in_valid <= 1'b0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b0;
        model_halted = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_data_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_data_q.size() != 0) begin
            $display("Timeout: %0d expected outputs never appeared", exp_data_q.size());
            errors++;
            exp_data_q.delete();
            exp_check_q.delete();
            exp_rd_q.delete();
            exp_rw_q.delete();
            exp_wwd_q.delete();
            exp_wwd_data_q.delete();
        end
    endtask

    task automatic test_reset_idle();
        repeat (10) begin
            @(negedge clk);
            check_flag("wb_valid", wb_valid, 1'b0);
            check_flag("wwd_valid", wwd_valid, 1'b0);
            check_flag("halted", halted, 1'b0);
        end
    endtask

    task automatic test_alu_ops();
        logic [2:0] op;
        repeat (2) begin
            for (int i = 0; i < 8; i++) begin
                op = i[2:0];
                rng = xorshift32(rng);
                send_alu(cpu_pkg::alu_op_t'(op), rng[15:0], rng[31:16], rng[1:0]);
            end
        end
        idle_input();
        wait_drain();
    endtask

    task automatic send_alu(input cpu_pkg::alu_op_t op, input cpu_pkg::word_t a,
                            input cpu_pkg::word_t b, input cpu_pkg::reg_idx_t r);
        send_instr(op, a, b, 16'h0000, r, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic test_store_load();
        cpu_pkg::word_t addr;
        repeat (6) begin
            rng  = xorshift32(rng);
            addr = {8'h00, rng[7:0]};
            send_instr(cpu_pkg::ALU_PASS_B, 16'h0000, addr, rng[31:16], 2'd0,
                       1'b0, 1'b0, 1'b1, 1'b0, 1'b0);  // Store
            send_instr(cpu_pkg::ALU_PASS_B, 16'h0000, addr, 16'h0000, rng[9:8],
                       1'b1, 1'b1, 1'b0, 1'b0, 1'b0);  // Load right behind it
        end
        idle_input();
        wait_drain();
    endtask

    task automatic test_wwd();
        rng = xorshift32(rng);
        send_alu(cpu_pkg::ALU_OR, rng[15:0], rng[31:16], 2'd1);
        // Nonzero src_b keeps the ALU result apart from src_a
        send_instr(cpu_pkg::ALU_ADD, rng[31:16], rng[15:0], 16'h0000, 2'd2,
                   1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        rng = xorshift32(rng);
        send_instr(cpu_pkg::ALU_SUB, rng[15:0], rng[31:16], 16'h0000, 2'd3,
                   1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        idle_input();
        wait_drain();
    endtask

    task automatic test_halt();
        int cycles;
        rng = xorshift32(rng);
        send_alu(cpu_pkg::ALU_SUB, rng[15:0], rng[31:16], 2'd0);
        send_instr(cpu_pkg::ALU_ADD, 16'h0000, 16'h0000, 16'h0000, 2'd0,
                   1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        repeat (3) begin
            rng = xorshift32(rng);
            send_alu(cpu_pkg::ALU_ADD, rng[15:0], rng[31:16], 2'd3);  // Must be dropped
        end
        send_instr(cpu_pkg::ALU_ADD, 16'h1234, 16'h0000, 16'h0000, 2'd0,
                   1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        idle_input();
        cycles = 0;
        while (!halted && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("Timeout: halted never rose after the halt instruction");
            errors++;
        end
        wait_drain();
        repeat (20) begin
            @(negedge clk);
            check_flag("halted", halted, 1'b1);
        end
        apply_reset();
        @(negedge clk);
        check_flag("halted", halted, 1'b0);
        send_alu(cpu_pkg::ALU_ADD, 16'h0003, 16'h0004, 2'd2);
        idle_input();
        wait_drain();
    endtask

    initial begin
        #200000;
        $display("Watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        errors       = 0;
        rng          = 32'hb0d3;
        model_halted = 1'b0;
        reset_n    <= 1'b1;
        in_valid   <= 1'b0;
        alu_op     <= cpu_pkg::ALU_ADD;
        src_a      <= '0;
        src_b      <= '0;
        store_data <= '0;
        rd         <= '0;
        mem_read   <= 1'b0;
        mem_write  <= 1'b0;
        reg_write  <= 1'b0;
        mem_to_reg <= 1'b0;
        is_wwd     <= 1'b0;
        is_halt    <= 1'b0;
        apply_reset();
        test_reset_idle();
        test_alu_ops();
        test_store_load();
        test_wwd();
        test_halt();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
cpu_pkg.sv
alu_exec.sv
stage_reg.sv
mem_access.sv
backend_top.sv
tb_backend.sv

//--- run.sh
#!/bin/sh
# Build and run the backend testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_backend \
    -f flist.f \
    -o sim_backend

out=$(./obj_dir/sim_backend)
echo "$out"

if echo "$out" | grep -q "TESTS PASSED"; then
    exit 0
else
    exit 1
fi
